// ==== logic/mask_restart_pkg.sv ====
`default_nettype none

package mask_restart_pkg;

   // one restart lane per aggregation pipe.
   localparam int num_pipes = 4;

   typedef logic [num_pipes-1:0] pipe_mask_t;

   typedef logic [19:0] hold_cnt_t;

   typedef logic [3:0] release_cnt_t;

   typedef logic [1:0] wr_mode_t;

   localparam wr_mode_t wr_mode_normal  = 2'd0;
   localparam wr_mode_t wr_mode_restart = 2'd2;

   typedef enum logic [2:0] {
      st_idle,
      st_clear_hold,
      st_clear_release,
      st_wait_frame,
      st_wait_update,
      st_over
   } restart_state_e;

endpackage

`default_nettype wire

// ==== logic/restart_lane_if.sv ====
`default_nettype none

interface restart_lane_if;
   import mask_restart_pkg::*;

   logic     req;
   logic     frame_start;
   logic     update;
   logic     clear;

   // mask memory controls and window, driven by the lane.
   logic     mem_clear;
   wr_mode_t wr_mode;
   logic     window;

   modport feed (
      output req,
      output frame_start,
      output update,
      output clear
   );

   modport lane (
      input  req,
      input  frame_start,
      input  update,
      input  clear,
      output mem_clear,
      output wr_mode,
      output window
   );

   modport drain (
      input mem_clear,
      input wr_mode,
      input window,
      input clear
   );

endinterface

`default_nettype wire

// ==== logic/restart_request_fanout.sv ====
`default_nettype none

module restart_request_fanout (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          clear,
   input  wire                          video_mask_restart,
   input  wire mask_restart_pkg::pipe_mask_t pipe_mask_bitmap,
   input  wire mask_restart_pkg::pipe_mask_t pipe_concat_en,
   input  wire                          frame_active,
   input  wire mask_restart_pkg::pipe_mask_t update_mask,
   restart_lane_if.feed                 lanes [mask_restart_pkg::num_pipes]
);
   import mask_restart_pkg::*;

   pipe_mask_t req_q;
   pipe_mask_t update_q;
   logic       frame_active_q;
   logic       frame_start_q;
   logic       frame_rise;

   // a pipe is selected only when it is in the bitmap and concatenation is on.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_q    <= '0;
         update_q <= '0;
      end else begin
         req_q    <= {num_pipes{video_mask_restart}} & pipe_mask_bitmap & pipe_concat_en;
         update_q <= update_mask;
      end
   end

   assign frame_rise = frame_active && !frame_active_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         frame_active_q <= 1'b0;
         frame_start_q  <= 1'b0;
      end else begin
         frame_active_q <= frame_active;
         frame_start_q  <= frame_rise;
      end
   end

   // the frame start is shared, requests and strobes are per pipe.
   for (genvar i = 0; i < num_pipes; i++) begin : g_feed
      assign lanes[i].req         = req_q[i];
      assign lanes[i].frame_start = frame_start_q;
      assign lanes[i].update      = update_q[i];
      assign lanes[i].clear       = clear;
   end

endmodule

`default_nettype wire

// ==== logic/pipe_restart_lane.sv ====
`default_nettype none

module pipe_restart_lane (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire mask_restart_pkg::hold_cnt_t    restart_hold_threshold,
   input  wire mask_restart_pkg::release_cnt_t clear_release_threshold,
   restart_lane_if.lane                   lane
);
   import mask_restart_pkg::*;

   restart_state_e state_q;
   restart_state_e state_d;
   hold_cnt_t      hold_cnt_q;
   release_cnt_t   release_cnt_q;
   logic           hold_at_thr;
   logic           hold_done;
   logic           release_done;
   logic           mem_clear_q;
   wr_mode_t       wr_mode_q;

   assign hold_at_thr  = (hold_cnt_q == restart_hold_threshold);
   assign hold_done    = (state_q == st_clear_hold) && lane.req && hold_at_thr;
   assign release_done = (state_q == st_clear_release)
                         && (release_cnt_q == clear_release_threshold);

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (lane.req) begin
               state_d = st_clear_hold;
            end
         end
         st_clear_hold: begin
            // the hold is abandoned as soon as the request goes away.
            if (hold_done) begin
               state_d = st_clear_release;
            end else if (!lane.req) begin
               state_d = st_idle;
            end
         end
         st_clear_release: begin
            if (release_done) begin
               state_d = st_wait_frame;
            end
         end
         st_wait_frame: begin
            if (lane.frame_start) begin
               state_d = st_wait_update;
            end
         end
         st_wait_update: begin
            if (lane.update) begin
               state_d = st_over;
            end
         end
         st_over: begin
            state_d = st_idle;
         end
         default: begin
            state_d = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= st_idle;
      end else if (lane.clear) begin
         state_q <= st_idle;
      end else begin
         state_q <= state_d;
      end
   end

   // both counters saturate at their threshold and restart from one.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hold_cnt_q <= hold_cnt_t'(1);
      end else if (lane.clear || (state_q == st_over)) begin
         hold_cnt_q <= hold_cnt_t'(1);
      end else if ((state_q == st_clear_hold) && lane.req && !hold_at_thr) begin
         hold_cnt_q <= hold_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         release_cnt_q <= release_cnt_t'(1);
      end else if (lane.clear || (state_q == st_over)) begin
         release_cnt_q <= release_cnt_t'(1);
      end else if ((state_q == st_clear_release) && !release_done) begin
         release_cnt_q <= release_cnt_q + 1'b1;
      end
   end

   // a clear puts the memory back into clear so it cannot be left released.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_clear_q <= 1'b1;
         wr_mode_q   <= wr_mode_normal;
      end else if (lane.clear || (state_q == st_over)) begin
         mem_clear_q <= 1'b1;
         wr_mode_q   <= wr_mode_normal;
      end else begin
         if (hold_done) begin
            mem_clear_q <= 1'b0;
         end
         if (release_done) begin
            wr_mode_q <= wr_mode_restart;
         end
      end
   end

   assign lane.mem_clear = mem_clear_q;
   assign lane.wr_mode   = wr_mode_q;
   assign lane.window    = hold_at_thr;

endmodule

`default_nettype wire

// ==== logic/pipe_restart_status.sv ====
`default_nettype none

module pipe_restart_status (
   input  wire                                   clk,
   input  wire                                   rst_n,
   restart_lane_if.drain                         lanes [mask_restart_pkg::num_pipes],
   output mask_restart_pkg::pipe_mask_t          pipe_mem_clear,
   output mask_restart_pkg::wr_mode_t [mask_restart_pkg::num_pipes-1:0] pipe_wr_mode,
   output mask_restart_pkg::pipe_mask_t          pipe_restart_window,
   output mask_restart_pkg::pipe_mask_t          restart_done
);
   import mask_restart_pkg::*;

   pipe_mask_t                   mem_clear_in;
   wr_mode_t [num_pipes-1:0]     wr_mode_in;
   pipe_mask_t                   window_in;
   pipe_mask_t                   clear_in;
   pipe_mask_t                   clear_q;
   pipe_mask_t                   done_set;

   // pipe_wr_mode holds the previous lane write mode, so a restart to normal
   // step marks a finished restart. A step caused by a clear does not count.
   for (genvar i = 0; i < num_pipes; i++) begin : g_collect
      assign mem_clear_in[i] = lanes[i].mem_clear;
      assign wr_mode_in[i]   = lanes[i].wr_mode;
      assign window_in[i]    = lanes[i].window;
      assign clear_in[i]     = lanes[i].clear;
      assign done_set[i]     = (wr_mode_in[i] == wr_mode_normal)
                               && (pipe_wr_mode[i] == wr_mode_restart)
                               && !clear_q[i];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pipe_mem_clear      <= '1;
         pipe_wr_mode        <= {num_pipes{wr_mode_normal}};
         pipe_restart_window <= '0;
         clear_q             <= '0;
      end else begin
         pipe_mem_clear      <= mem_clear_in;
         pipe_wr_mode        <= wr_mode_in;
         pipe_restart_window <= window_in;
         clear_q             <= clear_in;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         restart_done <= '0;
      end else begin
         restart_done <= (restart_done | done_set) & ~clear_in;
      end
   end

endmodule

`default_nettype wire

// ==== logic/pipe_restart_top.sv ====
`default_nettype none

module pipe_restart_top (
   input  wire                                   clk,
   input  wire                                   rst_n,
   input  wire                                   clear,
   input  wire                                   video_mask_restart,
   input  wire mask_restart_pkg::pipe_mask_t     pipe_mask_bitmap,
   input  wire mask_restart_pkg::pipe_mask_t     pipe_concat_en,
   input  wire                                   frame_active,
   input  wire mask_restart_pkg::pipe_mask_t     update_mask,
   input  wire mask_restart_pkg::hold_cnt_t      restart_hold_threshold,
   input  wire mask_restart_pkg::release_cnt_t   clear_release_threshold,
   output mask_restart_pkg::pipe_mask_t          pipe_mem_clear,
   output mask_restart_pkg::wr_mode_t [mask_restart_pkg::num_pipes-1:0] pipe_wr_mode,
   output mask_restart_pkg::pipe_mask_t          pipe_restart_window,
   output mask_restart_pkg::pipe_mask_t          restart_done
);
   import mask_restart_pkg::*;

   restart_lane_if lanes_if [num_pipes] ();

   restart_request_fanout u_fanout (
      .clk                (clk),
      .rst_n              (rst_n),
      .clear              (clear),
      .video_mask_restart (video_mask_restart),
      .pipe_mask_bitmap   (pipe_mask_bitmap),
      .pipe_concat_en     (pipe_concat_en),
      .frame_active       (frame_active),
      .update_mask        (update_mask),
      .lanes              (lanes_if)
   );

   // every pipe gets its own restart state machine, all sharing the thresholds.
   for (genvar i = 0; i < num_pipes; i++) begin : g_lane
      pipe_restart_lane u_lane (
         .clk                     (clk),
         .rst_n                   (rst_n),
         .restart_hold_threshold  (restart_hold_threshold),
         .clear_release_threshold (clear_release_threshold),
         .lane                    (lanes_if[i])
      );
   end

   pipe_restart_status u_status (
      .clk                 (clk),
      .rst_n               (rst_n),
      .lanes               (lanes_if),
      .pipe_mem_clear      (pipe_mem_clear),
      .pipe_wr_mode        (pipe_wr_mode),
      .pipe_restart_window (pipe_restart_window),
      .restart_done        (restart_done)
   );

endmodule

`default_nettype wire

// ==== bench/pipe_restart_tb.sv ====
`default_nettype none

module pipe_restart_tb;
   import mask_restart_pkg::*;

   localparam int clk_period = 10;
   localparam int max_lines  = 128;
   localparam stim_path      = "bench/pipe_restart_stim.txt";

   // each stim line holds input values for a number of cycles and then the expected outputs.
   typedef struct packed {
      logic [15:0]            cycles;
      logic                   clear;
      logic                   restart;
      pipe_mask_t             bitmap;
      pipe_mask_t             concat_en;
      logic                   frame;
      pipe_mask_t             update;
      hold_cnt_t              hold_thr;
      release_cnt_t           release_thr;
      pipe_mask_t             mem_clear;
      logic [2*num_pipes-1:0] wr_mode;
      pipe_mask_t             window;
      pipe_mask_t             done;
   } vector_t;

   logic                     clk;
   logic                     rst_n;
   logic                     clear;
   logic                     video_mask_restart;
   pipe_mask_t               pipe_mask_bitmap;
   pipe_mask_t               pipe_concat_en;
   logic                     frame_active;
   pipe_mask_t               update_mask;
   hold_cnt_t                restart_hold_threshold;
   release_cnt_t             clear_release_threshold;
   pipe_mask_t               pipe_mem_clear;
   wr_mode_t [num_pipes-1:0] pipe_wr_mode;
   pipe_mask_t               pipe_restart_window;
   pipe_mask_t               restart_done;

   vector_t                  vectors [max_lines];
   int                       num_lines;
   int                       total_cycles;
   logic                     stim_loaded;
   string                    load_msg;

   pipe_restart_top dut0 (
      .clk                     (clk),
      .rst_n                   (rst_n),
      .clear                   (clear),
      .video_mask_restart      (video_mask_restart),
      .pipe_mask_bitmap        (pipe_mask_bitmap),
      .pipe_concat_en          (pipe_concat_en),
      .frame_active            (frame_active),
      .update_mask             (update_mask),
      .restart_hold_threshold  (restart_hold_threshold),
      .clear_release_threshold (clear_release_threshold),
      .pipe_mem_clear          (pipe_mem_clear),
      .pipe_wr_mode            (pipe_wr_mode),
      .pipe_restart_window     (pipe_restart_window),
      .restart_done            (restart_done)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic load_stim(output string msg);
      int               fd;
      int               n;
      int               got;
      int               line_no;
      int               f [13];
      logic [8*200-1:0] text;
      msg     = "";
      line_no = 0;
      fd      = $fopen(stim_path, "r");
      if (fd == 0) begin
         msg = $sformatf("cannot open the stimulus file %s", stim_path);
      end else begin
         while (!$feof(fd) && msg == "") begin
            text = '0;
            n    = $fgets(text, fd);
            line_no++;
            got = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                          f[7], f[8], f[9], f[10], f[11], f[12]);
            // comment and blank lines yield no field at all.
            if (n > 0 && got == 13 && f[0] > 0 && num_lines < max_lines) begin
               vectors[num_lines].cycles      = 16'(f[0]);
               vectors[num_lines].clear       = (f[1] != 0);
               vectors[num_lines].restart     = (f[2] != 0);
               vectors[num_lines].bitmap      = pipe_mask_t'(f[3]);
               vectors[num_lines].concat_en   = pipe_mask_t'(f[4]);
               vectors[num_lines].frame       = (f[5] != 0);
               vectors[num_lines].update      = pipe_mask_t'(f[6]);
               vectors[num_lines].hold_thr    = hold_cnt_t'(f[7]);
               vectors[num_lines].release_thr = release_cnt_t'(f[8]);
               vectors[num_lines].mem_clear   = pipe_mask_t'(f[9]);
               vectors[num_lines].wr_mode     = (2*num_pipes)'(f[10]);
               vectors[num_lines].window      = pipe_mask_t'(f[11]);
               vectors[num_lines].done        = pipe_mask_t'(f[12]);
               total_cycles += f[0];
               num_lines++;
            end else if (n > 0 && got > 0) begin
               msg = $sformatf("stimulus line %0d cannot be used", line_no);
            end
         end
         $fclose(fd);
         if (msg == "" && num_lines == 0) begin
            msg = "the stimulus file holds no vectors";
         end
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, expected);
         $display("SOME TESTS FAILED");
         $fatal(1, "output mismatch on %s", name);
      end
   endtask

   task automatic apply_vector(input vector_t v);
      clear                   = v.clear;
      video_mask_restart      = v.restart;
      pipe_mask_bitmap        = v.bitmap;
      pipe_concat_en          = v.concat_en;
      frame_active            = v.frame;
      update_mask             = v.update;
      restart_hold_threshold  = v.hold_thr;
      clear_release_threshold = v.release_thr;
   endtask

   task automatic check_outputs(input vector_t v);
      check_value("pipe_mem_clear", pipe_mem_clear, v.mem_clear);
      check_value("pipe_wr_mode", pipe_wr_mode, v.wr_mode);
      check_value("pipe_restart_window", pipe_restart_window, v.window);
      check_value("restart_done", restart_done, v.done);
   endtask

   // inputs change one unit after an edge and outputs are sampled just before the next edge.
   task automatic run_vectors();
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < num_lines; i++) begin
         @(posedge clk);
         #1;
         apply_vector(vectors[i]);
         repeat (vectors[i].cycles - 1) @(posedge clk);
         #(clk_period - 2);
         check_outputs(vectors[i]);
      end
   endtask

   initial begin
      clk                     = 1'b0;
      rst_n                   = 1'b0;
      clear                   = 1'b0;
      video_mask_restart      = 1'b0;
      pipe_mask_bitmap        = '0;
      pipe_concat_en          = '0;
      frame_active            = 1'b0;
      update_mask             = '0;
      restart_hold_threshold  = '0;
      clear_release_threshold = '0;
      num_lines               = 0;
      total_cycles            = 0;
      stim_loaded             = 1'b0;
      load_stim(load_msg);
      if (load_msg != "") begin
         $display("%s", load_msg);
         $display("SOME TESTS FAILED");
         $fatal(1, "stimulus could not be loaded");
      end else begin
         stim_loaded = 1'b1;
         run_vectors();
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

   // the limit allows twice the cycles that the stim file asks for.
   initial begin
      wait (stim_loaded);
      #(2 * total_cycles * clk_period);
      $display("timeout: the stimulus did not complete in time");
      $display("SOME TESTS FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// ==== project.f ====
logic/mask_restart_pkg.sv
logic/restart_lane_if.sv
logic/restart_request_fanout.sv
logic/pipe_restart_lane.sv
logic/pipe_restart_status.sv
logic/pipe_restart_top.sv
bench/pipe_restart_tb.sv

// ==== Bender.yml ====
package:
  name: pipe_restart

sources:
  - logic/mask_restart_pkg.sv
  - logic/restart_lane_if.sv
  - logic/restart_request_fanout.sv
  - logic/pipe_restart_lane.sv
  - logic/pipe_restart_status.sv
  - logic/pipe_restart_top.sv
  - target: test
    files:
      - bench/pipe_restart_tb.sv

// ==== bench/pipe_restart_stim.txt ====
# cycles clear restart bitmap concat_en frame update hold_thr release_thr (inputs, hex)
# then expected mem_clear wr_mode window done at the last cycle of the line (hex)
# reset state
2 0 0 0 0 0 0 3 2  f 00 0 0
# pipe 0 full restart
6 0 1 1 1 0 0 3 2  f 00 1 0
1 0 1 1 1 0 0 3 2  e 00 1 0
1 0 0 1 1 0 0 3 2  e 00 1 0
1 0 0 1 1 0 0 3 2  e 02 1 0
3 0 0 0 0 0 0 3 2  e 02 1 0
4 0 0 0 0 1 0 3 2  e 02 1 0
1 0 0 0 0 1 1 3 2  e 02 1 0
3 0 0 0 0 1 0 3 2  e 02 1 0
1 0 0 0 0 0 0 3 2  f 00 0 1
# pipe 1 request dropped during the hold
2 0 1 2 f 0 0 3 2  f 00 0 1
5 0 0 2 f 0 0 3 2  f 00 0 1
# only pipe 2 is selected
6 0 1 5 c 0 0 3 2  f 00 4 1
1 0 1 5 c 0 0 3 2  b 00 4 1
2 0 0 5 c 0 0 3 2  b 20 4 1
2 0 0 5 c 1 0 3 2  b 20 4 1
1 0 0 5 c 1 f 3 2  b 20 4 1
3 0 0 5 c 1 0 3 2  b 20 4 1
1 0 0 5 c 0 0 3 2  f 00 0 5
# pipe 3 cleared while waiting for the frame
6 0 1 8 8 0 0 3 2  f 00 8 5
1 0 1 8 8 0 0 3 2  7 00 8 5
2 0 0 8 8 0 0 3 2  7 80 8 5
1 1 0 8 8 0 0 3 2  7 80 8 5
1 0 0 8 8 0 0 3 2  7 80 8 0
2 0 0 0 0 0 0 3 2  f 00 0 0
# pipes 0 and 2 together, updates on different cycles
6 0 1 5 f 0 0 3 2  f 00 5 0
1 0 1 5 f 0 0 3 2  a 00 5 0
2 0 0 5 f 0 0 3 2  a 22 5 0
2 0 0 5 f 1 0 3 2  a 22 5 0
1 0 0 5 f 1 1 3 2  a 22 5 0
1 0 0 5 f 1 0 3 2  a 22 5 0
1 0 0 5 f 1 4 3 2  a 22 5 0
1 0 0 5 f 1 0 3 2  a 22 5 0
1 0 0 5 f 1 0 3 2  b 20 4 1
1 0 0 5 f 1 0 3 2  b 20 4 1
2 0 0 0 0 0 0 3 2  f 00 0 5
